// File: src/soc_pkg.sv
// shared widths, bus op codes, slave map and device table constants; 32-bit data, three slaves only
`default_nettype none

package soc_pkg;

	// data and word address widths
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = ARCHBITSZ - 2;

	typedef logic [ARCHBITSZ-1:0] arch_t;
	typedef logic [ADDRBITSZ-1:0] addr_t;
	typedef logic [(ARCHBITSZ/8)-1:0] sel_t;

	localparam int GPIOCOUNT = 8;

	typedef logic [GPIOCOUNT-1:0] gpio_t;

	// pi1 op codes; code 3 (read-write swap) is reserved
	typedef enum logic [1:0] {
		PI1_NOP   = 2'd0,
		PI1_WRITE = 2'd1,
		PI1_READ  = 2'd2
	} pi1_op_e;

	// slave index in address map order from word 0
	typedef logic [1:0] slave_t;

	localparam slave_t S_DEVTBL     = 2'd0;
	localparam slave_t S_GPIO       = 2'd1;
	localparam slave_t S_INVALIDDEV = 2'd2;

	localparam int SLAVECOUNT = 3;

	// every slave owns 4 KB of the map
	localparam addr_t MAPSZ_WORDS = addr_t'(1024);

	// device table contents
	localparam arch_t SOCID            = 32'd4;
	localparam arch_t DEVID_DEVTBL     = 32'd7;
	localparam arch_t DEVID_GPIO       = 32'd6;
	localparam arch_t DEVID_INVALIDDEV = 32'd0;
	localparam arch_t MAPSZ_BYTES      = 32'h1000;

	// reset counter short enough for simulation
	localparam int RST_CNTR_BITSZ = 6;

	typedef logic [RST_CNTR_BITSZ-1:0] rst_cntr_t;

endpackage

`default_nettype wire

// File: src/pi1_if.sv
// decoded pi1 request between the decode and device stages; valid pulses one cycle per request
`default_nettype none

interface pi1_if;

	import soc_pkg::*;

	// one request in flight, so no ready path back on this link
	logic    valid;
	pi1_op_e op;
	// word offset inside the selected slave
	addr_t   offset;
	arch_t   data;
	sel_t    sel;
	slave_t  slave;

	modport decode (
		output valid,
		output op,
		output offset,
		output data,
		output sel,
		output slave
	);

	modport dev_stage (
		input valid,
		input op,
		input offset,
		input data,
		input sel,
		input slave
	);

endinterface

`default_nettype wire

// File: src/soc_reset.sv
// device reset from rst_p, a reload counter and devtbl requests; power-off holds until rst_p pulses
`default_nettype none

module soc_reset (
	input  wire  clk_4x_w,
	input  wire  rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic dev_rst_o
);

	import soc_pkg::*;

	rst_cntr_t rst_cntr_q;
	logic      pwroff_q;
	logic      sw_cold;
	logic      sw_warm;
	logic      sw_pwroff;

	// software request decode
	assign sw_cold   = rst0_i & rst1_i;
	assign sw_warm   = ~rst0_i & rst1_i;
	assign sw_pwroff = rst0_i & ~rst1_i;

	// no global reset here, so cold falls back to a warm reload
	always_ff @(posedge clk_4x_w) begin
		if (rst_p || sw_warm || sw_cold) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// the power-off latch is cleared only by the external reset
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign dev_rst_o = rst_p | pwroff_q | (|rst_cntr_q);

	// a latched power-off only goes away after rst_p
	a_pwroff_hold: assert property (@(posedge clk_4x_w)
		($past(pwroff_q) && !pwroff_q) |-> $past(rst_p));

endmodule

`default_nettype wire

// File: src/pi1_decode.sv
// pi1 decode stage; master must hold op until rdy, only one request is in flight at a time
`default_nettype none

module pi1_decode (
	input  wire               clk_4x_w,
	input  wire               rst_i,
	input  soc_pkg::pi1_op_e  op_i,
	input  soc_pkg::addr_t    addr_i,
	input  soc_pkg::arch_t    data_i,
	input  soc_pkg::sel_t     sel_i,
	input  logic              rdy_i,
	pi1_if.decode             req
);

	import soc_pkg::*;

	logic   busy_q;
	logic   accept;
	slave_t slave_d;
	addr_t  offset_d;

	assign accept = !busy_q && (op_i != PI1_NOP);

	// slaves are laid out back to back in index order
	always_comb begin
		if (addr_i < MAPSZ_WORDS) begin
			slave_d = S_DEVTBL;
		end else if (addr_i < (MAPSZ_WORDS << 1)) begin
			slave_d = S_GPIO;
		end else begin
			slave_d = S_INVALIDDEV;
		end
		offset_d = addr_i - (addr_t'(slave_d) * MAPSZ_WORDS);
	end

	// busy from accept until the device stage answers
	always_ff @(posedge clk_4x_w) begin
		if (rst_i) begin
			busy_q    <= 1'b0;
			req.valid <= 1'b0;
		end else begin
			req.valid <= accept;
			if (accept) begin
				busy_q <= 1'b1;
			end else if (rdy_i) begin
				busy_q <= 1'b0;
			end
		end
	end

	// request payload
	always_ff @(posedge clk_4x_w) begin
		if (accept) begin
			req.op     <= op_i;
			req.offset <= offset_d;
			req.data   <= data_i;
			req.sel    <= sel_i;
			req.slave  <= slave_d;
		end
	end

	// the swap op is not part of this bus, so it must never get through
	a_no_reserved_op: assert property (@(posedge clk_4x_w) disable iff (rst_i)
		accept |=> (req.valid && (req.op inside {PI1_WRITE, PI1_READ})));

endmodule

`default_nettype wire

// File: src/devtbl.sv
// device table with fixed ids and map sizes; word 0 write with sel[0] sets the reset requests
`default_nettype none

module devtbl (
	input  wire             clk_4x_w,
	input  wire             rst_i,
	input  logic            wr_i,
	input  soc_pkg::addr_t  rd_offset_i,
	input  soc_pkg::arch_t  data_i,
	input  soc_pkg::sel_t   sel_i,
	output soc_pkg::arch_t  data_o,
	output logic            rst0_o,
	output logic            rst1_o
);

	import soc_pkg::*;

	logic  rst0_q;
	logic  rst1_q;
	addr_t entry;

	// device id per slave index
	function automatic arch_t devid(input slave_t idx);
		arch_t id;
		case (idx)
			S_DEVTBL:     id = DEVID_DEVTBL;
			S_GPIO:       id = DEVID_GPIO;
			S_INVALIDDEV: id = DEVID_INVALIDDEV;
			default:      id = '0;
		endcase
		return id;
	endfunction

	// each device takes two words from word 2 on with the id before the map size
	assign entry = rd_offset_i - addr_t'(2);

	always_comb begin
		data_o = '0;
		if (rd_offset_i == addr_t'(0)) begin
			data_o = SOCID;
		end else if (rd_offset_i == addr_t'(1)) begin
			data_o = arch_t'(SLAVECOUNT);
		end else if (rd_offset_i < addr_t'(2 + 2 * SLAVECOUNT)) begin
			if (entry[0]) begin
				data_o = MAPSZ_BYTES;
			end else begin
				data_o = devid(slave_t'(entry >> 1));
			end
		end
	end

	// bit 0 asks for power-off, bit 1 for warm reset, both for cold
	always_ff @(posedge clk_4x_w) begin
		if (rst_i) begin
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else if (wr_i && (rd_offset_i == addr_t'(0)) && sel_i[0]) begin
			rst0_q <= data_i[0];
			rst1_q <= data_i[1];
		end
	end

	assign rst0_o = rst0_q;
	assign rst1_o = rst1_q;

endmodule

`default_nettype wire

// File: src/gpio.sv
// eight-bit gpio; inputs pass a two-flop synchronizer, outputs load only with sel[0] on word 0
`default_nettype none

module gpio (
	input  wire             clk_4x_w,
	input  wire             rst_i,
	input  logic            wr_i,
	input  soc_pkg::addr_t  offset_i,
	input  soc_pkg::arch_t  data_i,
	input  soc_pkg::sel_t   sel_i,
	input  soc_pkg::gpio_t  gp_i,
	output soc_pkg::arch_t  data_o,
	output soc_pkg::gpio_t  gp_o
);

	import soc_pkg::*;

	gpio_t gp_meta_q;
	gpio_t gp_sync_q;
	gpio_t out_q;

	// input synchronizer
	always_ff @(posedge clk_4x_w) begin
		gp_meta_q <= gp_i;
		gp_sync_q <= gp_meta_q;
	end

	always_ff @(posedge clk_4x_w) begin
		if (rst_i) begin
			out_q <= '0;
		end else if (wr_i && (offset_i == addr_t'(0)) && sel_i[0]) begin
			out_q <= data_i[GPIOCOUNT-1:0];
		end
	end

	// word 0 reads inputs, word 1 reads back the outputs
	always_comb begin
		case (offset_i)
			addr_t'(0): data_o = arch_t'(gp_sync_q);
			addr_t'(1): data_o = arch_t'(out_q);
			default:    data_o = '0;
		endcase
	end

	assign gp_o = out_q;

endmodule

`default_nettype wire

// File: src/dev_stage.sv
// device access stage; answers every request one cycle after valid, default slave reads zero
`default_nettype none

module dev_stage (
	input  wire             clk_4x_w,
	input  wire             rst_i,
	pi1_if.dev_stage        req,
	input  soc_pkg::gpio_t  gp_i,
	output soc_pkg::arch_t  data_o,
	output logic            rdy_o,
	output soc_pkg::gpio_t  gp_o,
	output logic            rst0_o,
	output logic            rst1_o
);

	import soc_pkg::*;

	logic  is_write;
	logic  wr_devtbl;
	logic  wr_gpio;
	arch_t devtbl_data;
	arch_t gpio_data;
	arch_t rd_data_d;
	arch_t data_q;
	logic  rdy_q;

	// write strobes go to the selected slave only
	assign is_write  = req.valid && (req.op == PI1_WRITE);
	assign wr_devtbl = is_write && (req.slave == S_DEVTBL);
	assign wr_gpio   = is_write && (req.slave == S_GPIO);

	devtbl i_devtbl (
		.clk_4x_w    (clk_4x_w),
		.rst_i       (rst_i),
		.wr_i        (wr_devtbl),
		.rd_offset_i (req.offset),
		.data_i      (req.data),
		.sel_i       (req.sel),
		.data_o      (devtbl_data),
		.rst0_o      (rst0_o),
		.rst1_o      (rst1_o)
	);

	gpio i_gpio (
		.clk_4x_w (clk_4x_w),
		.rst_i    (rst_i),
		.wr_i     (wr_gpio),
		.offset_i (req.offset),
		.data_i   (req.data),
		.sel_i    (req.sel),
		.gp_i     (gp_i),
		.data_o   (gpio_data),
		.gp_o     (gp_o)
	);

	// writes and the default slave read back zero
	always_comb begin
		rd_data_d = '0;
		if (req.op == PI1_READ) begin
			case (req.slave)
				S_DEVTBL: rd_data_d = devtbl_data;
				S_GPIO:   rd_data_d = gpio_data;
				default:  rd_data_d = '0;
			endcase
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (req.valid) begin
			data_q <= rd_data_d;
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= req.valid;
		end
	end

	assign data_o = data_q;
	assign rdy_o  = rdy_q;

	a_one_strobe: assert property (@(posedge clk_4x_w) disable iff (rst_i)
		$onehot0({wr_devtbl, wr_gpio}));

endmodule

`default_nettype wire

// File: src/soc_top.sv
// bus and system control top; single pi1 master, fixed two-cycle latency, all on clk_4x_w
`default_nettype none

module soc_top (
	input  wire               clk_4x_w,
	input  wire               rst_p,
	input  soc_pkg::pi1_op_e  pi1_op_i,
	input  soc_pkg::addr_t    pi1_addr_i,
	input  soc_pkg::arch_t    pi1_data_i,
	input  soc_pkg::sel_t     pi1_sel_i,
	output soc_pkg::arch_t    pi1_data_o,
	output logic              pi1_rdy_o,
	input  soc_pkg::gpio_t    gp_i,
	output soc_pkg::gpio_t    gp_o,
	output logic              dev_rst_o
);

	logic rst0_w;
	logic rst1_w;

	pi1_if req_if ();

	// dev_rst_o also resets everything below
	soc_reset i_soc_reset (
		.clk_4x_w  (clk_4x_w),
		.rst_p     (rst_p),
		.rst0_i    (rst0_w),
		.rst1_i    (rst1_w),
		.dev_rst_o (dev_rst_o)
	);

	pi1_decode i_pi1_decode (
		.clk_4x_w (clk_4x_w),
		.rst_i    (dev_rst_o),
		.op_i     (pi1_op_i),
		.addr_i   (pi1_addr_i),
		.data_i   (pi1_data_i),
		.sel_i    (pi1_sel_i),
		.rdy_i    (pi1_rdy_o),
		.req      (req_if.decode)
	);

	dev_stage i_dev_stage (
		.clk_4x_w (clk_4x_w),
		.rst_i    (dev_rst_o),
		.req      (req_if.dev_stage),
		.gp_i     (gp_i),
		.data_o   (pi1_data_o),
		.rdy_o    (pi1_rdy_o),
		.gp_o     (gp_o),
		.rst0_o   (rst0_w),
		.rst1_o   (rst1_w)
	);

endmodule

`default_nettype wire

// File: verification/tb_clk.sv
// free-running testbench clock, 4 ns period, starts low at time zero
`default_nettype none

module tb_clk (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
	end

	// half period of 2 ns
	always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: verification/tb_soc.sv
// random pi1 traffic against a model of the address map; stops at the first mismatch
`default_nettype none

module tb_soc;

	timeunit 1ns;
	timeprecision 100ps;

	import soc_pkg::*;

	localparam int MAP_WORDS  = 1024;
	localparam int N_TBL_RAND = 24;
	localparam int N_INV      = 24;
	localparam int N_GPIO     = 24;
	localparam int N_RAND     = 160;
	localparam int NUM_OPS    = 8 + N_TBL_RAND + N_INV + 2 + 4 * N_GPIO + N_RAND + 6;
	localparam int NUM_RESETS = 4;
	localparam int TIMEOUT_CYCLES = 4 * NUM_OPS + 100 * NUM_RESETS + 200;

	logic    clk_4x_w;
	logic    rst_p;
	pi1_op_e pi1_op_i;
	addr_t   pi1_addr_i;
	arch_t   pi1_data_i;
	sel_t    pi1_sel_i;
	arch_t   pi1_data_o;
	logic    pi1_rdy_o;
	gpio_t   gp_i;
	gpio_t   gp_o;
	logic    dev_rst_o;

	// reference model state
	arch_t tbl_model [0:7];
	gpio_t gp_out_model;
	gpio_t gp_in_model;
	int    cycle_cnt;

	tb_clk i_tb_clk (
		.clk_o (clk_4x_w)
	);

	soc_top i_soc_top (
		.clk_4x_w   (clk_4x_w),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.gp_i       (gp_i),
		.gp_o       (gp_o),
		.dev_rst_o  (dev_rst_o)
	);

	task automatic fail_stop();
		$display("Done: errors found");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_data(input string name, input arch_t got, input arch_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_rdy(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			fail_stop();
		end
	endtask

	// samples and drives 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_4x_w);
		#1;
	endtask

	// devtbl words 0 to 7 and gpio words 0 and 1 hold data and everything else reads zero
	function automatic arch_t model_read(input addr_t addr);
		arch_t v;
		v = '0;
		if (addr < MAP_WORDS) begin
			if (addr < 8) begin
				v = tbl_model[addr[2:0]];
			end
		end else if (addr == MAP_WORDS) begin
			v = arch_t'(gp_in_model);
		end else if (addr == MAP_WORDS + 1) begin
			v = arch_t'(gp_out_model);
		end
		return v;
	endfunction

	function automatic void model_write(input addr_t addr, input arch_t data, input sel_t sel);
		if ((addr == MAP_WORDS) && sel[0]) begin
			gp_out_model = data[7:0];
		end
	endfunction

	function automatic addr_t rand_addr();
		addr_t a;
		case ($urandom % 4)
			0: a = addr_t'($urandom % 16);
			1: a = addr_t'(MAP_WORDS + ($urandom % 4));
			2: a = addr_t'($urandom % (2 * MAP_WORDS));
			default: a = addr_t'($urandom);
		endcase
		return a;
	endfunction

	// one transfer; rdy must come exactly 2 cycles after the op and last one cycle
	task automatic bus_op(input pi1_op_e op, input addr_t addr, input arch_t wdata,
			input sel_t sel, output arch_t rdata);
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = wdata;
		pi1_sel_i  = sel;
		next_cycle();
		check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b0);
		next_cycle();
		check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b1);
		rdata    = pi1_data_o;
		pi1_op_i = PI1_NOP;
		next_cycle();
		check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b0);
	endtask

	task automatic do_read(input addr_t addr);
		arch_t rd;
		bus_op(PI1_READ, addr, arch_t'($urandom), sel_t'($urandom), rd);
		check_data("pi1_data_o", rd, model_read(addr));
	endtask

	task automatic do_write(input addr_t addr, input arch_t data, input sel_t sel);
		arch_t rd;
		arch_t wdata;
		wdata = data;
		// keep the reset request bits clear outside the reset tests
		if (addr == 0) begin
			wdata[1:0] = 2'b00;
		end
		bus_op(PI1_WRITE, addr, wdata, sel, rd);
		model_write(addr, wdata, sel);
		check_gpio("gp_o", gp_o, gp_out_model);
	endtask

	// gp_i only moves with no op in flight, then settles through the synchronizer
	task automatic set_gpin(input gpio_t v);
		gp_i        = v;
		gp_in_model = v;
		repeat (3) begin
			next_cycle();
			check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b0);
		end
	endtask

	task automatic reset_release();
		int n;
		rst_p = 1'b1;
		repeat (16) next_cycle();
		rst_p = 1'b0;
		n     = 0;
		while (dev_rst_o && (n < 100)) begin
			check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b0);
			next_cycle();
			n++;
		end
		if (n != 63) begin
			$display("dev_rst_o released %0d cycles after rst_p fell, expected 63", n);
			fail_stop();
		end
		gp_out_model = '0;
		check_gpio("gp_o", gp_o, gp_out_model);
	endtask

	// runaway guard
	always @(posedge clk_4x_w) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			fail_stop();
		end
	end

	initial begin
		int    n;
		arch_t rd;
		rst_p      = 1'b1;
		pi1_op_i   = PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		gp_i       = '0;
		cycle_cnt  = 0;
		gp_in_model  = '0;
		gp_out_model = '0;
		// soc id, device count, then id and map size per slave
		tbl_model[0] = 32'd4;
		tbl_model[1] = 32'd3;
		tbl_model[2] = 32'd7;
		tbl_model[3] = 32'h1000;
		tbl_model[4] = 32'd6;
		tbl_model[5] = 32'h1000;
		tbl_model[6] = 32'd0;
		tbl_model[7] = 32'h1000;
		void'($urandom(32'h7550c153));
		#1;
		reset_release();

		// device table and default slave
		for (int i = 0; i < 8; i++) begin
			do_read(addr_t'(i));
		end
		for (int i = 0; i < N_TBL_RAND; i++) begin
			do_read(addr_t'($urandom % MAP_WORDS));
		end
		do_read(addr_t'(2 * MAP_WORDS));
		do_read('1);
		for (int i = 0; i < N_INV; i++) begin
			do_read(addr_t'(2 * MAP_WORDS) + addr_t'($urandom % 32'h3fff_f800));
		end

		// gpio writes with random byte enables
		for (int i = 0; i < N_GPIO; i++) begin
			set_gpin(gpio_t'($urandom));
			do_write(addr_t'(MAP_WORDS), arch_t'($urandom), sel_t'($urandom));
			do_read(addr_t'(MAP_WORDS + 1));
			do_read(addr_t'(MAP_WORDS));
		end

		// mixed traffic
		for (int i = 0; i < N_RAND; i++) begin
			if ($urandom % 2) begin
				do_read(rand_addr());
			end else begin
				do_write(rand_addr(), arch_t'($urandom), sel_t'($urandom));
			end
			if ($urandom % 2) begin
				next_cycle();
				check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b0);
			end
		end

		// warm reset request
		do_write(addr_t'(MAP_WORDS), 32'h0000_005a, 4'b0001);
		bus_op(PI1_WRITE, '0, 32'd2, 4'b0001, rd);
		n = 1;
		while (!dev_rst_o && (n < 3)) begin
			next_cycle();
			n++;
		end
		if (!dev_rst_o) begin
			$display("dev_rst_o did not rise within 3 cycles of the warm request");
			fail_stop();
		end
		n = 0;
		while (dev_rst_o && (n < 100)) begin
			check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b0);
			next_cycle();
			n++;
		end
		if ((n < 63) || (n > 66)) begin
			$display("warm reset held dev_rst_o for %0d cycles, expected 63 to 66", n);
			fail_stop();
		end
		gp_out_model = '0;
		check_gpio("gp_o", gp_o, gp_out_model);
		do_read(addr_t'(MAP_WORDS + 1));

		// power-off holds until rst_p pulses
		bus_op(PI1_WRITE, '0, 32'd1, 4'b0001, rd);
		repeat (200) begin
			if (dev_rst_o !== 1'b1) begin
				$display("dev_rst_o dropped while power-off was latched");
				fail_stop();
			end
			check_rdy("pi1_rdy_o", pi1_rdy_o, 1'b0);
			next_cycle();
		end
		reset_release();
		do_read('0);
		do_read(addr_t'(MAP_WORDS + 1));

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
src/soc_pkg.sv
src/pi1_if.sv
src/soc_reset.sv
src/pi1_decode.sv
src/devtbl.sv
src/gpio.sv
src/dev_stage.sv
src/soc_top.sv
verification/tb_clk.sv
verification/tb_soc.sv
